// ==== rtl/apuPkg.sv ====
package apuPkg;

  // ============================================================
  // Datapath widths
  // ============================================================

  // Output level of one pulse channel
  typedef logic [3:0] sampleT;

  // Sum of both channel levels
  typedef logic [4:0] mixT;

  typedef logic [10:0] periodT;
  typedef logic [7:0] lenCountT;

  // Index into the length table, from data bits 7..3
  typedef logic [4:0] lenIndexT;

  typedef logic [7:0] regByteT;

  // ============================================================
  // Channel register map, low two address bits
  // ============================================================
  typedef enum logic [1:0] {
    regDutyVol  = 2'd0,
    regSweep    = 2'd1,
    regPeriodLo = 2'd2,
    regPeriodHi = 2'd3
  } chanRegT;

endpackage

// ==== rtl/lengthTable.sv ====
module lengthTable import apuPkg::*; (
  input  lenIndexT index,
  output lenCountT length
);

  // Standard console length values, in half frames
  always_comb begin
    case (index)
      5'd0:    length = 8'd10;
      5'd1:    length = 8'd254;
      5'd2:    length = 8'd20;
      5'd3:    length = 8'd2;
      5'd4:    length = 8'd40;
      5'd5:    length = 8'd4;
      5'd6:    length = 8'd80;
      5'd7:    length = 8'd6;
      5'd8:    length = 8'd160;
      5'd9:    length = 8'd8;
      5'd10:   length = 8'd60;
      5'd11:   length = 8'd10;
      5'd12:   length = 8'd14;
      5'd13:   length = 8'd12;
      5'd14:   length = 8'd26;
      5'd15:   length = 8'd14;
      5'd16:   length = 8'd12;
      5'd17:   length = 8'd16;
      5'd18:   length = 8'd24;
      5'd19:   length = 8'd18;
      5'd20:   length = 8'd48;
      5'd21:   length = 8'd20;
      5'd22:   length = 8'd96;
      5'd23:   length = 8'd22;
      5'd24:   length = 8'd192;
      5'd25:   length = 8'd24;
      5'd26:   length = 8'd72;
      5'd27:   length = 8'd26;
      5'd28:   length = 8'd16;
      5'd29:   length = 8'd28;
      5'd30:   length = 8'd32;
      default: length = 8'd30;
    endcase
  end

endmodule

// ==== rtl/frameSequencer.sv ====
module frameSequencer #(
  parameter int FramePeriod = 7457
) (
  input  logic clk,
  input  logic reset,
  input  logic ce,
  output logic quarterTick,
  output logic halfTick
);

  localparam int CountW = (FramePeriod > 1) ? $clog2(FramePeriod) : 1;

  logic [CountW-1:0] tickCount;
  logic              frameWrap;
  logic              halfPhase;

  // Last ce tick of a quarter frame
  assign frameWrap = ce && (tickCount == CountW'(FramePeriod - 1));

  // ============================================================
  // Quarter-frame divider
  // ============================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      tickCount <= '0;
      halfPhase <= 1'b0;
    end else if (ce) begin
      if (frameWrap) begin
        tickCount <= '0;
        halfPhase <= ~halfPhase;
      end else begin
        tickCount <= tickCount + 1'b1;
      end
    end
  end

  // Strobes line up with the ce tick that ends the quarter frame
  assign quarterTick = frameWrap;
  // every second quarter is also a half frame
  assign halfTick = frameWrap && halfPhase;

endmodule

// ==== rtl/squareChan.sv ====
module squareChan import apuPkg::*; #(
  parameter bit SecondChannel = 1'b0
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     ce,
  input  logic     chanWrite,
  input  chanRegT  regSel,
  input  regByteT  regData,
  input  lenCountT lengthLoad,
  input  logic     halfTick,
  input  logic     quarterTick,
  input  logic     enabled,
  output sampleT   sample,
  output logic     lengthActive
);

  logic [1:0]  duty;
  logic        envLoop;
  logic        constVol;
  logic        envRestart;
  sampleT      volume;
  sampleT      envLevel;
  logic [3:0]  envDivider;
  logic        sweepEnable;
  logic        sweepNegate;
  logic        sweepReload;
  logic [2:0]  sweepPeriod;
  logic [2:0]  sweepDivider;
  logic [2:0]  sweepShift;
  periodT      period;
  logic [11:0] timerCount;
  logic [2:0]  seqPos;
  lenCountT    lenCount;

  periodT      shiftedPeriod;
  periodT      sweepDelta;
  logic [11:0] sweepTarget;
  logic        freqValid;
  logic        dutyHigh;

  // ============================================================
  // Sweep target and mute condition
  // ============================================================
  assign shiftedPeriod = period >> sweepShift;
  // First channel negates with ones' complement, second with two's
  assign sweepDelta = sweepNegate ? (~shiftedPeriod + periodT'(SecondChannel))
                                  : shiftedPeriod;
  assign sweepTarget = {1'b0, period} + {1'b0, sweepDelta};
  assign freqValid = (period >= 11'd8) && (sweepNegate || !sweepTarget[11]);

  // Length halt shares the envelope loop bit
  assign lengthActive = (lenCount != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      duty         <= '0;
      envLoop      <= 1'b0;
      constVol     <= 1'b0;
      envRestart   <= 1'b0;
      volume       <= '0;
      envLevel     <= '0;
      envDivider   <= '0;
      sweepEnable  <= 1'b0;
      sweepNegate  <= 1'b0;
      sweepReload  <= 1'b0;
      sweepPeriod  <= '0;
      sweepDivider <= '0;
      sweepShift   <= '0;
      period       <= '0;
      timerCount   <= '0;
      seqPos       <= '0;
      lenCount     <= '0;
    end else if (ce) begin
      // Half-rate timer gives 2 * (period + 1) ticks per step
      if (timerCount == '0) begin
        timerCount <= {period, 1'b1};
        seqPos     <= seqPos - 3'd1;
      end else begin
        timerCount <= timerCount - 12'd1;
      end

      if (halfTick && lenCount != '0 && !envLoop)
        lenCount <= lenCount - 8'd1;

      if (halfTick) begin
        if (sweepReload || sweepDivider == '0)
          sweepDivider <= sweepPeriod;
        else
          sweepDivider <= sweepDivider - 3'd1;
        if (sweepDivider == '0 && sweepEnable && sweepShift != '0 && freqValid)
          period <= sweepTarget[10:0];
        sweepReload <= 1'b0;
      end

      if (quarterTick) begin
        if (envRestart) begin
          envLevel   <= 4'd15;
          envDivider <= volume;
          envRestart <= 1'b0;
        end else if (envDivider == '0) begin
          envDivider <= volume;
          if (envLevel != '0 || envLoop)
            envLevel <= envLevel - 4'd1;
        end else begin
          envDivider <= envDivider - 4'd1;
        end
      end

      // Register writes win over the periodic updates above
      if (chanWrite) begin
        case (regSel)
          regDutyVol: begin
            duty     <= regData[7:6];
            envLoop  <= regData[5];
            constVol <= regData[4];
            volume   <= regData[3:0];
          end
          regSweep: begin
            sweepEnable <= regData[7];
            sweepPeriod <= regData[6:4];
            sweepNegate <= regData[3];
            sweepShift  <= regData[2:0];
            sweepReload <= 1'b1;
          end
          regPeriodLo: period[7:0] <= regData;
          regPeriodHi: begin
            period[10:8] <= regData[2:0];
            lenCount     <= lengthLoad;
            envRestart   <= 1'b1;
            seqPos       <= '0;
          end
          default: ;
        endcase
      end

      if (!enabled)
        lenCount <= '0;
    end
  end

  // ============================================================
  // Output level
  // ============================================================
  always_comb begin
    case (duty)
      2'd0:    dutyHigh = (seqPos == 3'd7);
      2'd1:    dutyHigh = (seqPos >= 3'd6);
      2'd2:    dutyHigh = (seqPos >= 3'd4);
      default: dutyHigh = (seqPos < 3'd6);
    endcase
    if (lenCount == '0 || !freqValid || !dutyHigh)
      sample = '0;
    else
      sample = constVol ? volume : envLevel;
  end

endmodule

// ==== rtl/pulseMixer.sv ====
module pulseMixer import apuPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   ce,
  input  sampleT sampleA,
  input  sampleT sampleB,
  output mixT    mixSample,
  output logic   sampleValid,
  input  logic   sampleReady
);

  mixT  levelSum;
  logic slotFree;
  logic capture;

  // Linear sum, one spare bit for the carry
  assign levelSum = {1'b0, sampleA} + {1'b0, sampleB};

  // ============================================================
  // One-entry output register
  // ============================================================

  // Free when empty or when the held sample leaves this cycle
  assign slotFree = !sampleValid || sampleReady;
  assign capture  = ce && slotFree;

  always_ff @(posedge clk) begin
    if (reset) begin
      sampleValid <= 1'b0;
    end else if (capture) begin
      sampleValid <= 1'b1;
    end else if (sampleReady) begin
      sampleValid <= 1'b0;
    end
  end

  // Held steady while stalled
  always_ff @(posedge clk) begin
    if (capture)
      mixSample <= levelSum;
  end

endmodule

// ==== rtl/apuPulsePair.sv ====
module apuPulsePair import apuPkg::*; #(
  parameter int FramePeriod = 7457
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       ce,
  input  logic       regWrite,
  input  logic [2:0] regAddr,
  input  regByteT    regData,
  input  logic [1:0] chanEnable,
  output logic [1:0] lengthActive,
  output mixT        mixSample,
  output logic       sampleValid,
  input  logic       sampleReady
);

  logic     quarterTick;
  logic     halfTick;
  logic     chanWrite0;
  logic     chanWrite1;
  chanRegT  regSel;
  lenCountT lengthLoad;
  sampleT   sample0;
  sampleT   sample1;

  // ============================================================
  // Address decode, bit 2 picks the channel
  // ============================================================
  assign regSel     = chanRegT'(regAddr[1:0]);
  assign chanWrite0 = regWrite && !regAddr[2];
  assign chanWrite1 = regWrite && regAddr[2];

  frameSequencer #(.FramePeriod(FramePeriod)) frameSeq (
    .clk, .reset, .ce,
    .quarterTick, .halfTick
  );

  // Shared by both channels
  lengthTable lenTable (
    .index  (lenIndexT'(regData[7:3])),
    .length (lengthLoad)
  );

  squareChan #(.SecondChannel(1'b0)) chan0 (
    .clk, .reset, .ce,
    .chanWrite (chanWrite0),
    .regSel, .regData, .lengthLoad,
    .halfTick, .quarterTick,
    .enabled      (chanEnable[0]),
    .sample       (sample0),
    .lengthActive (lengthActive[0])
  );

  squareChan #(.SecondChannel(1'b1)) chan1 (
    .clk, .reset, .ce,
    .chanWrite (chanWrite1),
    .regSel, .regData, .lengthLoad,
    .halfTick, .quarterTick,
    .enabled      (chanEnable[1]),
    .sample       (sample1),
    .lengthActive (lengthActive[1])
  );

  pulseMixer mixer (
    .clk, .reset, .ce,
    .sampleA (sample0),
    .sampleB (sample1),
    .mixSample, .sampleValid, .sampleReady
  );

endmodule

// ==== tb/apuPulsePair_properties.sv ====
module apuPulsePairProperties import apuPkg::*; (
  input logic clk,
  input logic reset,
  input mixT  mixSample,
  input logic sampleValid,
  input logic sampleReady
);
  timeunit 1ns;
  timeprecision 1ns;

  int assertFails = 0;

  validLowAfterReset: assert property (@(posedge clk) reset |=> !sampleValid)
    else begin
      assertFails++;
      $error("sampleValid high in the cycle after reset");
    end

  // Stalled output must not move
  stallHoldsValid: assert property (@(posedge clk) disable iff (reset)
      sampleValid && !sampleReady |=> sampleValid)
    else begin
      assertFails++;
      $error("sampleValid dropped while stalled");
    end

  stallHoldsData: assert property (@(posedge clk) disable iff (reset)
      sampleValid && !sampleReady |=> $stable(mixSample))
    else begin
      assertFails++;
      $error("mixSample changed while stalled");
    end

endmodule

bind apuPulsePair apuPulsePairProperties props (
  .clk(clk), .reset(reset), .mixSample(mixSample),
  .sampleValid(sampleValid), .sampleReady(sampleReady)
);

// ==== tb/apuPulsePairTb.sv ====
module apuPulsePairTb import apuPkg::*; ;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int FramePeriod = 64;
  localparam int HalfFrame = 2 * FramePeriod;
  localparam int LenTab [32] = '{10, 254, 20, 2, 40, 4, 80, 6, 160, 8, 60, 10, 14, 12, 26, 14,
                                12, 16, 24, 18, 48, 20, 96, 22, 192, 24, 72, 26, 16, 28, 32, 30};

  logic clk, reset, ce, regWrite, sampleValid, sampleReady;
  logic [2:0] regAddr;
  regByteT regData;
  logic [1:0] chanEnable, lengthActive;
  mixT mixSample, expHigh;
  bit checkOn;
  int errors, checks, sampleCount, highCount, waited;

  apuPulsePair #(.FramePeriod(FramePeriod)) uut (
    .clk, .reset, .ce, .regWrite, .regAddr, .regData, .chanEnable,
    .lengthActive, .mixSample, .sampleValid, .sampleReady
  );

  always #50 clk = ~clk;

  // ============================================================
  // Reference model and checks
  // ============================================================
  function automatic mixT refLevel(input logic [1:0] duty, input sampleT vol,
                                   input logic [2:0] pos, input logic lenOn, input logic freqOk);
    logic [7:0] shape;
    case (duty)
      2'd0:    shape = 8'b0100_0000;
      2'd1:    shape = 8'b0110_0000;
      2'd2:    shape = 8'b0111_1000;
      default: shape = 8'b1001_1111;
    endcase
    // Leftmost bit is position 0
    if (shape[3'd7 - pos] && lenOn && freqOk)
      return mixT'(vol);
    return '0;
  endfunction

  // Mute rules for period and sweep target
  function automatic logic periodValid(input periodT p, input regByteT sweep);
    int target;
    target = int'(p) + int'(p >> sweep[2:0]);
    return (p >= 11'd8) && (sweep[3] || target < 2048);
  endfunction

  task automatic compare(input string name, input logic [31:0] expected, input logic [31:0] got);
    checks++;
    if (expected !== got) begin
      errors++;
      $display("mismatch %s expected 0x%0h got 0x%0h", name, expected, got);
    end
  endtask

  // Every transferred sample is either silent or the expected high level
  always @(posedge clk) begin
    if (!reset && sampleValid && sampleReady) begin
      sampleCount++;
      if (checkOn && mixSample != '0) begin
        highCount++;
        compare("mixSample", expHigh, mixSample);
      end
    end
  end

  // ============================================================
  // Stimulus helpers
  // ============================================================
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic writeReg(input logic [2:0] addr, input regByteT data);
    regWrite = 1'b1;
    regAddr = addr;
    regData = data;
    step();
    regWrite = 1'b0;
  endtask

  task automatic programChan(input logic chan, input regByteT dutyVol, sweep, periodLo, periodHi);
    writeReg({chan, 2'd0}, dutyVol);
    writeReg({chan, 2'd1}, sweep);
    writeReg({chan, 2'd2}, periodLo);
    writeReg({chan, 2'd3}, periodHi);
  endtask

  task automatic resetDut();
    reset = 1'b1;
    regWrite = 1'b0;
    sampleReady = 1'b1;
    chanEnable = 2'b11;
    checkOn = 1'b0;
    repeat (4) step();
    compare("sampleValid", 0, sampleValid);
    compare("lengthActive", 0, lengthActive);
    reset = 1'b0;
    step();
    compare("sampleValid", 1, sampleValid);
  endtask

  task automatic waitSamples(input int n);
    waited = 0;
    while (sampleCount < n && waited < 4 * n + 100) begin
      step();
      waited++;
    end
    if (sampleCount < n) begin
      errors++;
      $display("timeout: only %0d of %0d samples arrived", sampleCount, n);
    end
  endtask

  // One full duty sequence of samples
  task automatic expectWindow(input logic [1:0] duty, input sampleT vol, input periodT p,
                              input logic ok, input int chans);
    int expCount;
    mixT level;
    expCount = 0;
    level = '0;
    for (int pos = 0; pos < 8; pos++) begin
      if (refLevel(duty, vol, 3'(pos), 1'b1, ok) != '0) begin
        level = mixT'(chans * refLevel(duty, vol, 3'(pos), 1'b1, ok));
        expCount += 2 * (p + 1);
      end
    end
    expHigh = level;
    sampleCount = 0;
    highCount = 0;
    checkOn = 1'b1;
    waitSamples(16 * (p + 1));
    checkOn = 1'b0;
    compare("highCount", expCount, highCount);
  endtask

  task automatic runSingle(input logic [1:0] duty, input sampleT vol, input periodT p,
                           input regByteT sweep);
    resetDut();
    chanEnable = 2'b01;
    programChan(1'b0, {duty, 2'b01, vol}, sweep, p[7:0], {5'd1, p[10:8]});
    step();
    expectWindow(duty, vol, p, periodValid(p, sweep), 1);
  endtask

  initial begin
    void'($urandom(32'hf09f));
    clk = 1'b0;
    reset = 1'b1;
    ce = 1'b1;
    regWrite = 1'b0;
    regAddr = '0;
    regData = '0;
    chanEnable = 2'b11;
    sampleReady = 1'b1;
    expHigh = '0;
    errors = 0;
    checks = 0;

    for (int d = 0; d < 4; d++)
      runSingle(2'(d), sampleT'(d + 5), periodT'(8 + 7 * d), 8'h00);

    // ============================================================
    // Two channels, second written one full sequence later
    // ============================================================
    resetDut();
    programChan(1'b0, 8'h9b, 8'h00, 8'd10, 8'h08);
    repeat (16 * 11 - 4) step();
    programChan(1'b1, 8'h9b, 8'h00, 8'd10, 8'h08);
    compare("lengthActive", 2'b11, lengthActive);
    step();
    expectWindow(2'd2, 4'd11, 11'd10, 1'b1, 2);
    chanEnable = 2'b01;
    step();
    step();
    compare("lengthActive", 2'b01, lengthActive);
    expectWindow(2'd2, 4'd11, 11'd10, 1'b1, 1);

    // Length counter runs out
    resetDut();
    chanEnable = 2'b01;
    programChan(1'b0, 8'h1f, 8'h00, 8'd50, {5'd5, 3'd0});
    compare("lengthActive", 2'b01, lengthActive);
    waited = 0;
    while (lengthActive[0] && waited < (LenTab[5] + 1) * HalfFrame) begin
      step();
      waited++;
    end
    if (lengthActive[0]) begin
      errors++;
      $display("timeout: length counter of channel 0 never ran out");
    end else begin
      compare("lengthFallWindow", 1, waited > (LenTab[5] - 1) * HalfFrame &&
              waited <= LenTab[5] * HalfFrame);
    end
    writeReg(3'd3, {5'd1, 3'd0});
    compare("lengthActive", 2'b01, lengthActive);
    chanEnable = 2'b00;
    step();
    compare("lengthActive", 2'b00, lengthActive);

    // Short period, overflowing target, negated sweep
    runSingle(2'd2, 4'd12, 11'd5, 8'h00);
    runSingle(2'd3, 4'd7, 11'h600, 8'h01);
    runSingle(2'd3, 4'd7, 11'h600, 8'h09);

    // Random stalls on the output stream
    resetDut();
    chanEnable = 2'b01;
    programChan(1'b0, 8'h99, 8'h00, 8'd12, 8'h08);
    step();
    expHigh = refLevel(2'd2, 4'd9, 3'd2, 1'b1, 1'b1);
    highCount = 0;
    checkOn = 1'b1;
    repeat (600) begin
      sampleReady = 1'($urandom % 2);
      step();
    end
    sampleReady = 1'b1;
    checkOn = 1'b0;
    compare("highSeen", 1, highCount > 0);

    errors += uut.props.assertFails;
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== all.f ====
rtl/apuPkg.sv
rtl/lengthTable.sv
rtl/frameSequencer.sv
rtl/squareChan.sv
rtl/pulseMixer.sv
rtl/apuPulsePair.sv
tb/apuPulsePair_properties.sv
tb/apuPulsePairTb.sv

// ==== Bender.yml ====
package:
  name: apu_pulse_pair

sources:
  - rtl/apuPkg.sv
  - rtl/lengthTable.sv
  - rtl/frameSequencer.sv
  - rtl/squareChan.sv
  - rtl/pulseMixer.sv
  - rtl/apuPulsePair.sv
  - target: simulation
    files:
      - tb/apuPulsePair_properties.sv
      - tb/apuPulsePairTb.sv
